//--- src/cp0_pkg.sv
package cp0_pkg;

    typedef logic [31:0] word_t;       // Data word or address
    typedef logic [7:0]  cp0_addr_t;   // {rd, sel}
    typedef logic [4:0]  exc_code_t;   // Cause ExcCode field
    typedef logic [18:0] vpn2_t;       // Even/odd page pair number
    typedef logic [7:0]  asid_t;       // Address space id
    typedef logic [19:0] pfn_t;        // Physical frame number
    typedef logic [3:0]  tlb_idx_t;    // Entry index

    // Encoding matches Status.EXL so the state reads back directly
    typedef enum logic {
        EXL_USER = 1'b0,               // Normal level
        EXL_EXC  = 1'b1                // Exception level
    } exl_state_t;

    localparam int TLB_ENTRIES = 16;

    // Register addresses as (rd, sel)
    localparam cp0_addr_t ADDR_INDEX    = {5'd0, 3'd0};
    localparam cp0_addr_t ADDR_ENTRYLO0 = {5'd2, 3'd0};
    localparam cp0_addr_t ADDR_ENTRYLO1 = {5'd3, 3'd0};
    localparam cp0_addr_t ADDR_BADVADDR = {5'd8, 3'd0};
    localparam cp0_addr_t ADDR_COUNT    = {5'd9, 3'd0};
    localparam cp0_addr_t ADDR_ENTRYHI  = {5'd10, 3'd0};
    localparam cp0_addr_t ADDR_COMPARE  = {5'd11, 3'd0};
    localparam cp0_addr_t ADDR_STATUS   = {5'd12, 3'd0};
    localparam cp0_addr_t ADDR_CAUSE    = {5'd13, 3'd0};
    localparam cp0_addr_t ADDR_EPC      = {5'd14, 3'd0};

    // Exception codes
    localparam exc_code_t EXC_INT  = 5'd0;   // Interrupt
    localparam exc_code_t EXC_MOD  = 5'd1;   // TLB modified
    localparam exc_code_t EXC_TLBL = 5'd2;   // TLB refill/invalid on load
    localparam exc_code_t EXC_TLBS = 5'd3;   // TLB refill/invalid on store
    localparam exc_code_t EXC_ADEL = 5'd4;   // Address error on load or fetch
    localparam exc_code_t EXC_ADES = 5'd5;   // Address error on store
    localparam exc_code_t EXC_SYS  = 5'd8;   // Syscall

    // Timer
    localparam word_t COMPARE_RESET = 32'h000155cc;

endpackage

//--- src/cp0_timer.sv
`timescale 1ns/100ps

module cp0_timer import cp0_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      mtc0_we,
    input  cp0_addr_t cp0_addr,
    input  word_t     wdata,
    output word_t     count,
    output word_t     compare,
    output logic      timer_irq
);

    logic tick;          // Half-rate phase
    logic count_wr;
    logic compare_wr;

    assign count_wr   = mtc0_we && (cp0_addr == ADDR_COUNT);
    assign compare_wr = mtc0_we && (cp0_addr == ADDR_COMPARE);

    always_ff @(posedge clk) begin
        if (reset) begin
            tick <= 1'b0;
        end else begin
            tick <= ~tick;               // Unaffected by Count writes
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count   <= '0;
            compare <= COMPARE_RESET;
        end else begin
            if (count_wr) begin
                count <= wdata;
            end else if (tick) begin
                count <= count + 32'd1;  // Every second cycle
            end
            if (compare_wr) begin
                compare <= wdata;
            end
        end
    end

    // TI flag, cleared by a Compare write
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_irq <= 1'b0;
        end else if (compare_wr) begin
            timer_irq <= 1'b0;           // Acknowledge wins over a match
        end else if (count == compare) begin
            timer_irq <= 1'b1;
        end
    end

endmodule

//--- src/cp0_exc_ctrl.sv
`timescale 1ns/100ps

module cp0_exc_ctrl import cp0_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       ws_valid,
    input  logic       ws_mtc0,
    input  logic       ws_eret,
    input  logic       ws_ex,
    input  logic       ws_bd,
    input  exc_code_t  ws_exc_code,
    input  word_t      ws_pc,
    input  word_t      ws_data_addr,
    input  logic [4:0] ws_rd,
    input  logic [2:0] ws_sel,
    input  word_t      ws_result,
    input  word_t      count,
    input  word_t      compare,
    input  logic       timer_irq,
    input  word_t      entryhi_val,
    input  word_t      entrylo0_val,
    input  word_t      entrylo1_val,
    input  word_t      index_val,
    output logic       mtc0_we,
    output cp0_addr_t  cp0_addr,
    output logic       eret_flush,
    output word_t      epc,
    output logic       int_pending,
    output word_t      cp0_rdata
);

    exl_state_t state;
    exl_state_t state_next;
    logic       exl;
    logic       status_wr;
    logic       first_exc;       // Exception taken from user level
    logic       status_ie;
    logic [7:0] status_im;
    logic       cause_bd;
    logic       cause_ip7;
    logic [1:0] cause_ip_sw;     // Software interrupts IP1..0
    logic [7:0] cause_ip;
    exc_code_t  cause_exc_code;
    word_t      badvaddr;

    assign cp0_addr   = {ws_rd, ws_sel};
    assign mtc0_we    = ws_valid && ws_mtc0 && !ws_ex;
    assign eret_flush = ws_valid && ws_eret && !ws_ex;
    assign status_wr  = mtc0_we && (cp0_addr == ADDR_STATUS);
    assign exl        = (state == EXL_EXC);
    assign first_exc  = ws_ex && (state == EXL_USER);
    assign cause_ip   = {cause_ip7, 5'b00000, cause_ip_sw};   // IP6..2 unused

    // Exception level; exception over eret over mtc0
    always_comb begin
        state_next = state;
        if (ws_ex) begin
            state_next = EXL_EXC;
        end else if (eret_flush) begin
            state_next = EXL_USER;
        end else if (status_wr) begin
            state_next = ws_result[1] ? EXL_EXC : EXL_USER;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= EXL_USER;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            status_ie      <= 1'b0;
            status_im      <= '0;
            cause_bd       <= 1'b0;
            cause_ip7      <= 1'b0;
            cause_ip_sw    <= '0;
            cause_exc_code <= EXC_INT;
        end else begin
            cause_ip7 <= timer_irq;                 // One cycle behind TI
            if (status_wr) begin
                status_ie <= ws_result[0];
                status_im <= ws_result[15:8];
            end
            if (mtc0_we && (cp0_addr == ADDR_CAUSE)) begin
                cause_ip_sw <= ws_result[9:8];
            end
            if (first_exc) begin
                cause_bd <= ws_bd;
            end
            if (ws_ex) begin
                cause_exc_code <= ws_exc_code;      // Also on nested exceptions
            end
        end
    end

    always_ff @(posedge clk) begin
        if (first_exc) begin
            epc <= ws_bd ? ws_pc - 32'd4 : ws_pc;   // Point at the branch
        end else if (mtc0_we && (cp0_addr == ADDR_EPC)) begin
            epc <= ws_result;
        end
    end

    always_ff @(posedge clk) begin
        if (first_exc) begin
            case (ws_exc_code)
                EXC_ADES, EXC_MOD, EXC_TLBL, EXC_TLBS: badvaddr <= ws_data_addr;
                EXC_ADEL: badvaddr <= (ws_pc[1:0] != 2'b00) ? ws_pc : ws_data_addr;
                default: badvaddr <= badvaddr;
            endcase
        end
    end

    assign int_pending = status_ie && !exl && |(cause_ip & status_im);

    // mfc0 read path
    always_comb begin
        case (cp0_addr)
            ADDR_INDEX:    cp0_rdata = index_val;
            ADDR_ENTRYLO0: cp0_rdata = entrylo0_val;
            ADDR_ENTRYLO1: cp0_rdata = entrylo1_val;
            ADDR_BADVADDR: cp0_rdata = badvaddr;
            ADDR_COUNT:    cp0_rdata = count;
            ADDR_ENTRYHI:  cp0_rdata = entryhi_val;
            ADDR_COMPARE:  cp0_rdata = compare;
            ADDR_STATUS:   cp0_rdata = {9'b0, 1'b1, 6'b0, status_im, 6'b0, exl, status_ie};
            ADDR_CAUSE:    cp0_rdata = {cause_bd, timer_irq, 14'b0, cause_ip, 1'b0,
                                        cause_exc_code, 2'b00};
            ADDR_EPC:      cp0_rdata = epc;
            default:       cp0_rdata = '0;
        endcase
    end

endmodule

//--- src/cp0_tlb_regs.sv
`timescale 1ns/100ps

module cp0_tlb_regs import cp0_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       ws_valid,
    input  logic       ws_ex,
    input  exc_code_t  ws_exc_code,
    input  word_t      ws_data_addr,
    input  logic       ws_tlbr,
    input  logic       ws_tlbwi,
    input  logic       ws_tlbp,
    input  logic       mtc0_we,
    input  cp0_addr_t  cp0_addr,
    input  word_t      wdata,
    input  vpn2_t      rd_vpn2,
    input  asid_t      rd_asid,
    input  logic       rd_g,
    input  pfn_t       rd_pfn0,
    input  logic [4:0] rd_flags0,
    input  pfn_t       rd_pfn1,
    input  logic [4:0] rd_flags1,
    input  logic       hit,
    input  tlb_idx_t   hit_index,
    output logic       tlb_we,
    output tlb_idx_t   tlb_index,
    output vpn2_t      key_vpn2,
    output asid_t      key_asid,
    output pfn_t       wr_pfn0,
    output logic [4:0] wr_flags0,
    output pfn_t       wr_pfn1,
    output logic [4:0] wr_flags1,
    output logic       wr_g,
    output word_t      entryhi_val,
    output word_t      entrylo0_val,
    output word_t      entrylo1_val,
    output word_t      index_val
);

    vpn2_t      hi_vpn2;
    asid_t      hi_asid;
    pfn_t       lo0_pfn;
    logic [4:0] lo0_flags;       // {C, D, V}
    logic       lo0_g;
    pfn_t       lo1_pfn;
    logic [4:0] lo1_flags;
    logic       lo1_g;
    logic       idx_p;           // Probe failure
    tlb_idx_t   idx;
    logic       inst_ok;
    logic       tlb_exc;

    assign inst_ok = ws_valid && !ws_ex;
    assign tlb_exc = ws_ex && (ws_exc_code == EXC_TLBL || ws_exc_code == EXC_TLBS ||
                               ws_exc_code == EXC_MOD);

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_vpn2 <= '0;
            hi_asid <= '0;
            lo0_pfn <= '0;
            lo0_flags <= '0;
            lo0_g <= 1'b0;
            lo1_pfn <= '0;
            lo1_flags <= '0;
            lo1_g <= 1'b0;
            idx_p <= 1'b0;
            idx <= '0;
        end else if (tlb_exc) begin
            hi_vpn2 <= ws_data_addr[31:13];         // Faulting page pair
        end else if (inst_ok && ws_tlbr) begin
            hi_vpn2 <= rd_vpn2;
            hi_asid <= rd_asid;
            lo0_pfn <= rd_pfn0;
            lo0_flags <= rd_flags0;
            lo0_g <= rd_g;                          // Both halves see the joint G
            lo1_pfn <= rd_pfn1;
            lo1_flags <= rd_flags1;
            lo1_g <= rd_g;
        end else if (inst_ok && ws_tlbp) begin
            idx_p <= !hit;
            if (hit) begin
                idx <= hit_index;                   // Miss keeps the old index
            end
        end else if (mtc0_we) begin
            case (cp0_addr)
                ADDR_ENTRYHI: begin
                    hi_vpn2 <= wdata[31:13];
                    hi_asid <= wdata[7:0];
                end
                ADDR_ENTRYLO0: begin
                    lo0_pfn <= wdata[25:6];
                    lo0_flags <= wdata[5:1];
                    lo0_g <= wdata[0];
                end
                ADDR_ENTRYLO1: begin
                    lo1_pfn <= wdata[25:6];
                    lo1_flags <= wdata[5:1];
                    lo1_g <= wdata[0];
                end
                ADDR_INDEX: idx <= wdata[3:0];      // P is read-only
                default: ;
            endcase
        end
    end

    assign tlb_we    = inst_ok && ws_tlbwi;
    assign tlb_index = idx;
    assign key_vpn2  = hi_vpn2;
    assign key_asid  = hi_asid;
    assign wr_pfn0   = lo0_pfn;
    assign wr_flags0 = lo0_flags;
    assign wr_pfn1   = lo1_pfn;
    assign wr_flags1 = lo1_flags;
    assign wr_g      = lo0_g & lo1_g;

    assign entryhi_val  = {hi_vpn2, 5'b0, hi_asid};
    assign entrylo0_val = {6'b0, lo0_pfn, lo0_flags, lo0_g};
    assign entrylo1_val = {6'b0, lo1_pfn, lo1_flags, lo1_g};
    assign index_val    = {idx_p, 27'b0, idx};

endmodule

//--- src/tlb_array.sv
`timescale 1ns/100ps

module tlb_array import cp0_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       tlb_we,
    input  tlb_idx_t   tlb_index,
    input  vpn2_t      key_vpn2,
    input  asid_t      key_asid,
    input  pfn_t       wr_pfn0,
    input  logic [4:0] wr_flags0,
    input  pfn_t       wr_pfn1,
    input  logic [4:0] wr_flags1,
    input  logic       wr_g,
    output vpn2_t      rd_vpn2,
    output asid_t      rd_asid,
    output logic       rd_g,
    output pfn_t       rd_pfn0,
    output logic [4:0] rd_flags0,
    output pfn_t       rd_pfn1,
    output logic [4:0] rd_flags1,
    output logic       hit,
    output tlb_idx_t   hit_index
);

    vpn2_t                  mem_vpn2   [TLB_ENTRIES];
    asid_t                  mem_asid   [TLB_ENTRIES];
    logic                   mem_g      [TLB_ENTRIES];
    pfn_t                   mem_pfn0   [TLB_ENTRIES];
    logic [4:0]             mem_flags0 [TLB_ENTRIES];
    pfn_t                   mem_pfn1   [TLB_ENTRIES];
    logic [4:0]             mem_flags1 [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] entry_valid;   // Set by the first write
    logic [TLB_ENTRIES-1:0] match;

    always_ff @(posedge clk) begin
        if (reset) begin
            entry_valid <= '0;
        end else if (tlb_we) begin
            entry_valid[tlb_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_we) begin
            mem_vpn2[tlb_index]   <= key_vpn2;
            mem_asid[tlb_index]   <= key_asid;
            mem_g[tlb_index]      <= wr_g;
            mem_pfn0[tlb_index]   <= wr_pfn0;
            mem_flags0[tlb_index] <= wr_flags0;
            mem_pfn1[tlb_index]   <= wr_pfn1;
            mem_flags1[tlb_index] <= wr_flags1;
        end
    end

    // Indexed read for tlbr
    assign rd_vpn2   = mem_vpn2[tlb_index];
    assign rd_asid   = mem_asid[tlb_index];
    assign rd_g      = mem_g[tlb_index];
    assign rd_pfn0   = mem_pfn0[tlb_index];
    assign rd_flags0 = mem_flags0[tlb_index];
    assign rd_pfn1   = mem_pfn1[tlb_index];
    assign rd_flags1 = mem_flags1[tlb_index];

    // Associative search, lowest index wins
    always_comb begin
        hit_index = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            match[i] = entry_valid[i] && (mem_vpn2[i] == key_vpn2) &&
                       (mem_g[i] || (mem_asid[i] == key_asid));   // G ignores ASID
            if (match[i]) begin
                hit_index = tlb_idx_t'(i);
            end
        end
    end

    assign hit = |match;

endmodule

//--- src/cp0_subsys.sv
`timescale 1ns/100ps

module cp0_subsys import cp0_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       ws_valid,
    input  logic       ws_mtc0,
    input  logic       ws_eret,
    input  logic       ws_ex,
    input  logic       ws_bd,
    input  logic       ws_tlbr,
    input  logic       ws_tlbwi,
    input  logic       ws_tlbp,
    input  exc_code_t  ws_exc_code,
    input  word_t      ws_pc,
    input  word_t      ws_data_addr,
    input  logic [4:0] ws_rd,
    input  logic [2:0] ws_sel,
    input  word_t      ws_result,
    output word_t      cp0_rdata,
    output logic       eret_flush,
    output word_t      epc,
    output logic       int_pending
);

    logic       mtc0_we;
    cp0_addr_t  cp0_addr;
    word_t      count, compare;
    logic       timer_irq;
    word_t      entryhi_val, entrylo0_val, entrylo1_val, index_val;
    logic       tlb_we;
    tlb_idx_t   tlb_index;
    vpn2_t      key_vpn2, rd_vpn2;
    asid_t      key_asid, rd_asid;
    pfn_t       wr_pfn0, wr_pfn1, rd_pfn0, rd_pfn1;
    logic [4:0] wr_flags0, wr_flags1, rd_flags0, rd_flags1;
    logic       wr_g, rd_g;
    logic       hit;
    tlb_idx_t   hit_index;

    cp0_timer u_timer (
        .clk, .reset, .mtc0_we, .cp0_addr, .wdata(ws_result),
        .count, .compare, .timer_irq
    );

    cp0_exc_ctrl u_exc_ctrl (
        .clk, .reset, .ws_valid, .ws_mtc0, .ws_eret, .ws_ex, .ws_bd,
        .ws_exc_code, .ws_pc, .ws_data_addr, .ws_rd, .ws_sel, .ws_result,
        .count, .compare, .timer_irq,
        .entryhi_val, .entrylo0_val, .entrylo1_val, .index_val,
        .mtc0_we, .cp0_addr, .eret_flush, .epc, .int_pending, .cp0_rdata
    );

    cp0_tlb_regs u_tlb_regs (
        .clk, .reset, .ws_valid, .ws_ex, .ws_exc_code, .ws_data_addr,
        .ws_tlbr, .ws_tlbwi, .ws_tlbp, .mtc0_we, .cp0_addr, .wdata(ws_result),
        .rd_vpn2, .rd_asid, .rd_g, .rd_pfn0, .rd_flags0, .rd_pfn1, .rd_flags1,
        .hit, .hit_index,
        .tlb_we, .tlb_index, .key_vpn2, .key_asid,
        .wr_pfn0, .wr_flags0, .wr_pfn1, .wr_flags1, .wr_g,
        .entryhi_val, .entrylo0_val, .entrylo1_val, .index_val
    );

    tlb_array u_tlb_array (
        .clk, .reset, .tlb_we, .tlb_index, .key_vpn2, .key_asid,
        .wr_pfn0, .wr_flags0, .wr_pfn1, .wr_flags1, .wr_g,
        .rd_vpn2, .rd_asid, .rd_g, .rd_pfn0, .rd_flags0, .rd_pfn1, .rd_flags1,
        .hit, .hit_index
    );

endmodule

//--- tb/cp0_properties.sv
`timescale 1ns/100ps

module cp0_properties import cp0_pkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       ws_ex,
    input logic       eret_flush,
    input word_t      epc,
    input logic       int_pending,
    input exl_state_t state
);

    int unsigned violations = 0;   // Failed assertion count

    eret_to_user: assert property (@(posedge clk) disable iff (reset)
        eret_flush |=> (state == EXL_USER))
    else begin
        violations++;
        $error("State not back at user level after eret");
    end

    // Nested exception keeps the first return address
    epc_kept_nested: assert property (@(posedge clk) disable iff (reset)
        (ws_ex && state == EXL_EXC) |=> (epc === $past(epc)))
    else begin
        violations++;
        $error("EPC changed by an exception taken at exception level");
    end

    no_irq_after_exc: assert property (@(posedge clk) disable iff (reset)
        ws_ex |=> !int_pending)
    else begin
        violations++;
        $error("int_pending high in the cycle after an exception");
    end

endmodule

bind cp0_exc_ctrl cp0_properties u_props (
    .clk, .reset, .ws_ex, .eret_flush, .epc, .int_pending, .state
);

//--- tb/tb_cp0_subsys.sv
`timescale 1ns/100ps

module tb_cp0_subsys import cp0_pkg::*; ();

    localparam int REG_OPS       = 150;
    localparam int TIMER_ROUNDS  = 20;
    localparam int EXC_OPS       = 120;
    localparam int TLB_OPS       = 80;
    localparam int TLBEXC_ROUNDS = 10;
    // Worst case stimulus cycles over all tests
    localparam int MAX_CYCLES = 30 + REG_OPS * 3 + TIMER_ROUNDS * 29 + EXC_OPS * 2
                              + TLB_ENTRIES * 5 + TLB_OPS * 5 + TLBEXC_ROUNDS * 7;

    logic       clk = 1'b0;
    logic       reset;
    logic       ws_valid, ws_mtc0, ws_eret, ws_ex, ws_bd;
    logic       ws_tlbr, ws_tlbwi, ws_tlbp;
    exc_code_t  ws_exc_code;
    word_t      ws_pc, ws_data_addr, ws_result;
    logic [4:0] ws_rd;
    logic [2:0] ws_sel;
    word_t      cp0_rdata, epc;
    logic       eret_flush, int_pending;

    int   seed = 56;
    int   check_count = 0;
    int   err_count = 0;
    int   tests_run = 0;
    int   test_checks, test_errs;
    logic checking = 1'b0;   // Off until reset is released

    // Reference model
    logic       m_tick, m_ti, m_exl, m_ie, m_bd, m_ip7, m_p;
    logic [7:0] m_im;
    logic [1:0] m_ip_sw;
    word_t      m_count, m_compare, m_epc, m_badv, m_hi, m_lo0, m_lo1;
    exc_code_t  m_exc;
    tlb_idx_t   m_idx;
    logic       t_valid [TLB_ENTRIES];
    logic       t_g     [TLB_ENTRIES];
    word_t      t_hi    [TLB_ENTRIES];
    word_t      t_lo0   [TLB_ENTRIES];   // G bit kept apart in t_g
    word_t      t_lo1   [TLB_ENTRIES];

    cp0_addr_t reg_addrs [10] = '{ADDR_INDEX, ADDR_ENTRYLO0, ADDR_ENTRYLO1, ADDR_BADVADDR,
                                  ADDR_COUNT, ADDR_ENTRYHI, ADDR_COMPARE, ADDR_STATUS,
                                  ADDR_CAUSE, ADDR_EPC};
    cp0_addr_t exc_regs  [4]  = '{ADDR_EPC, ADDR_BADVADDR, ADDR_CAUSE, ADDR_STATUS};
    exc_code_t exc_codes [7]  = '{EXC_INT, EXC_MOD, EXC_TLBL, EXC_TLBS, EXC_ADEL, EXC_ADES,
                                  EXC_SYS};

    cp0_subsys u_dut (.*);

    always #2 clk = ~clk;

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    function automatic word_t rand_pc();
        word_t pc;
        pc = rand_word();
        if (rand_word() & 1) begin
            pc[1:0] = 2'b00;                 // Aligned half of the time
        end
        return pc;
    endfunction

    // Two VPN2 bits, junk in the unused field, two ASID bits
    function automatic word_t rand_hi();
        return rand_word() & 32'h0000_6f03;
    endfunction

    function automatic word_t expected_read(input cp0_addr_t a);
        word_t v;
        case (a)
            ADDR_INDEX:    v = {m_p, 27'd0, m_idx};
            ADDR_ENTRYLO0: v = m_lo0;
            ADDR_ENTRYLO1: v = m_lo1;
            ADDR_BADVADDR: v = m_badv;
            ADDR_COUNT:    v = m_count;
            ADDR_ENTRYHI:  v = m_hi;
            ADDR_COMPARE:  v = m_compare;
            ADDR_STATUS:   v = 32'h0040_0000 | {16'd0, m_im, 6'd0, m_exl, m_ie};   // BEV set
            ADDR_CAUSE:    v = {m_bd, m_ti, 14'd0, m_ip7, 5'd0, m_ip_sw, 1'b0, m_exc, 2'd0};
            ADDR_EPC:      v = m_epc;
            default:       v = '0;
        endcase
        return v;
    endfunction

    function automatic logic expected_irq();
        return m_ie && !m_exl && ((({m_ip7, 5'd0, m_ip_sw}) & m_im) != 8'd0);
    endfunction

    task automatic compare_word(input string what, input word_t got, input word_t exp);
        check_count++;
        assert (got === exp) else begin
            err_count++;
            $display("FAIL %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic idle_inputs();
        ws_valid = 1'b0;
        ws_mtc0 = 1'b0;
        ws_eret = 1'b0;
        ws_ex = 1'b0;
        ws_bd = 1'b0;
        ws_tlbr = 1'b0;
        ws_tlbwi = 1'b0;
        ws_tlbp = 1'b0;
        ws_exc_code = '0;
        ws_pc = '0;
        ws_data_addr = '0;
        ws_rd = '0;
        ws_sel = '0;
        ws_result = '0;
    endtask

    task automatic update_model();
        cp0_addr_t a;
        word_t     d;
        logic      wr, ret, ok, first, found;
        tlb_idx_t  hit_at;
        a = {ws_rd, ws_sel};
        d = ws_result;
        wr = ws_valid && ws_mtc0 && !ws_ex;
        ret = ws_valid && ws_eret && !ws_ex;
        ok = ws_valid && !ws_ex;
        first = ws_ex && !m_exl;
        if (reset) begin
            m_tick = 1'b0;
            m_count = '0;
            m_compare = COMPARE_RESET;
            m_ti = 1'b0;
            m_exl = 1'b0;
            m_ie = 1'b0;
            m_im = '0;
            m_ip7 = 1'b0;
            m_ip_sw = '0;
            m_bd = 1'b0;
            m_exc = EXC_INT;
            m_hi = '0;
            m_lo0 = '0;
            m_lo1 = '0;
            m_p = 1'b0;
            m_idx = '0;
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                t_valid[i] = 1'b0;
            end
        end else begin
            found = 1'b0;
            hit_at = '0;
            for (int i = 0; i < TLB_ENTRIES; i++) begin   // Lowest index wins
                if (!found && t_valid[i] && t_hi[i][31:13] == m_hi[31:13] &&
                    (t_g[i] || t_hi[i][7:0] == m_hi[7:0])) begin
                    found = 1'b1;
                    hit_at = tlb_idx_t'(i);
                end
            end
            if (ok && ws_tlbwi) begin
                t_hi[m_idx] = m_hi;
                t_lo0[m_idx] = m_lo0 & 32'hffff_fffe;
                t_lo1[m_idx] = m_lo1 & 32'hffff_fffe;
                t_g[m_idx] = m_lo0[0] & m_lo1[0];
                t_valid[m_idx] = 1'b1;
            end
            if (ws_ex && ws_exc_code inside {EXC_MOD, EXC_TLBL, EXC_TLBS}) begin
                m_hi[31:13] = ws_data_addr[31:13];
            end else if (ok && ws_tlbr) begin
                m_hi = t_hi[m_idx];
                m_lo0 = t_lo0[m_idx] | 32'(t_g[m_idx]);
                m_lo1 = t_lo1[m_idx] | 32'(t_g[m_idx]);
            end else if (ok && ws_tlbp) begin
                m_p = !found;
                if (found) begin
                    m_idx = hit_at;
                end
            end else if (wr) begin
                case (a)
                    ADDR_ENTRYHI:  m_hi = d & 32'hffff_e0ff;
                    ADDR_ENTRYLO0: m_lo0 = d & 32'h03ff_ffff;
                    ADDR_ENTRYLO1: m_lo1 = d & 32'h03ff_ffff;
                    ADDR_INDEX:    m_idx = d[3:0];
                    default: ;
                endcase
            end
            m_ip7 = m_ti;                                 // Old TI
            if (wr && a == ADDR_COMPARE) begin
                m_ti = 1'b0;
            end else if (m_count == m_compare) begin
                m_ti = 1'b1;
            end
            if (wr && a == ADDR_COUNT) begin
                m_count = d;
            end else if (m_tick) begin
                m_count = m_count + 1;
            end
            if (wr && a == ADDR_COMPARE) begin
                m_compare = d;
            end
            m_tick = !m_tick;
            if (wr && a == ADDR_STATUS) begin
                m_ie = d[0];
                m_im = d[15:8];
            end
            if (wr && a == ADDR_CAUSE) begin
                m_ip_sw = d[9:8];
            end
            if (first) begin
                m_bd = ws_bd;
                m_epc = ws_bd ? ws_pc - 4 : ws_pc;
                if (ws_exc_code inside {EXC_ADES, EXC_MOD, EXC_TLBL, EXC_TLBS}) begin
                    m_badv = ws_data_addr;
                end else if (ws_exc_code == EXC_ADEL) begin
                    m_badv = (ws_pc[1:0] != 2'b00) ? ws_pc : ws_data_addr;
                end
            end else if (wr && a == ADDR_EPC) begin
                m_epc = d;
            end
            if (ws_ex) begin
                m_exc = ws_exc_code;
            end
            if (ws_ex) begin
                m_exl = 1'b1;
            end else if (ret) begin
                m_exl = 1'b0;
            end else if (wr && a == ADDR_STATUS) begin
                m_exl = d[1];
            end
        end
    endtask

    // Entered 1 ns after an edge with the cycle's inputs driven
    task automatic advance();
        word_t exp;
        #2;                                               // Mid-cycle, outputs settled
        if (checking) begin
            exp = expected_read({ws_rd, ws_sel});
            if (!$isunknown(exp)) begin
                compare_word($sformatf("mfc0 %0d,%0d", ws_rd, ws_sel), cp0_rdata, exp);
            end
            compare_word("eret_flush", 32'(eret_flush), 32'(ws_valid && ws_eret && !ws_ex));
            compare_word("int_pending", 32'(int_pending), 32'(expected_irq()));
            if (!$isunknown(m_epc)) begin
                compare_word("epc", epc, m_epc);
            end
        end
        @(posedge clk);
        update_model();
        #1;
        idle_inputs();
    endtask

    task automatic mtc0_write(input cp0_addr_t a, input word_t d);
        ws_valid = 1'b1;
        ws_mtc0 = 1'b1;
        {ws_rd, ws_sel} = a;
        ws_result = d;
        advance();
    endtask

    task automatic mfc0_read(input cp0_addr_t a);
        ws_valid = 1'b1;
        {ws_rd, ws_sel} = a;
        advance();
    endtask

    task automatic raise_exc(input exc_code_t code, input word_t pc, input word_t addr,
                             input logic bd);
        ws_valid = 1'b1;
        ws_ex = 1'b1;
        ws_eret = 1'(rand_word());                        // Must be ignored
        ws_exc_code = code;
        ws_pc = pc;
        ws_data_addr = addr;
        ws_bd = bd;
        advance();
    endtask

    task automatic issue_eret();
        ws_valid = 1'b1;
        ws_eret = 1'b1;
        advance();
    endtask

    task automatic tlb_instr(input logic r, input logic wi, input logic p);
        ws_valid = 1'b1;
        ws_tlbr = r;
        ws_tlbwi = wi;
        ws_tlbp = p;
        advance();
    endtask

    task automatic write_entry(input tlb_idx_t i);
        mtc0_write(ADDR_INDEX, (rand_word() & 32'hffff_fff0) | i);   // P is read-only
        mtc0_write(ADDR_ENTRYHI, rand_hi());
        mtc0_write(ADDR_ENTRYLO0, rand_word());
        mtc0_write(ADDR_ENTRYLO1, rand_word());
        tlb_instr(1'b0, 1'b1, 1'b0);
    endtask

    task automatic start_test();
        test_checks = check_count;
        test_errs = err_count;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("%-14s %0d checks, %0d errors", name, check_count - test_checks,
                 err_count - test_errs);
    endtask

    initial begin
        #(MAX_CYCLES * 4 + 400);
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        word_t     c;
        cp0_addr_t ra;
        int        r;
        int        violations;
        idle_inputs();
        reset = 1'b1;
        @(posedge clk);
        update_model();
        #1;
        repeat (4) advance();
        reset = 1'b0;
        checking = 1'b1;

        start_test();
        foreach (reg_addrs[i]) begin
            mfc0_read(reg_addrs[i]);
        end
        mfc0_read({5'd7, 3'd0});                          // Unimplemented
        mfc0_read({5'd12, 3'd2});
        report_test("reset values");

        start_test();
        repeat (REG_OPS) begin
            ra = reg_addrs[rand_word() % 10];
            mtc0_write(ra, rand_word());
            mfc0_read(ra);
            if ((rand_word() & 3) == 0) begin
                mfc0_read(reg_addrs[rand_word() % 10]);
            end
        end
        report_test("mtc0/mfc0");

        start_test();
        repeat (TIMER_ROUNDS) begin
            c = rand_word();
            mtc0_write(ADDR_COUNT, c);
            mtc0_write(ADDR_COMPARE, c + (rand_word() & 7) + 1);
            r = 0;
            while (!m_ti && r < 24) begin
                mfc0_read(r[0] ? ADDR_CAUSE : ADDR_COUNT);
                r++;
            end
            mfc0_read(ADDR_CAUSE);                        // IP7 follows
            mtc0_write(ADDR_COMPARE, rand_word());
            mfc0_read(ADDR_CAUSE);
        end
        report_test("timer");

        start_test();
        mtc0_write(ADDR_STATUS, rand_word() & 32'h0000_ff01);
        mtc0_write(ADDR_CAUSE, rand_word());
        repeat (EXC_OPS) begin
            r = rand_word() % 8;
            case (r)
                0, 1, 2: raise_exc(exc_codes[rand_word() % 7], rand_pc(), rand_word(),
                                   1'(rand_word()));
                3, 4:    issue_eret();
                5:       mtc0_write(ADDR_STATUS, rand_word() & 32'h0000_ff03);
                6:       mtc0_write(ADDR_CAUSE, rand_word());
                default: mtc0_write(ADDR_EPC, rand_word());
            endcase
            mfc0_read(exc_regs[rand_word() % 4]);
        end
        report_test("exceptions");

        start_test();
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            write_entry(tlb_idx_t'(i));
        end
        repeat (TLB_OPS) begin
            r = rand_word() % 4;
            if (r == 0) begin
                write_entry(tlb_idx_t'(rand_word() % TLB_ENTRIES));
            end else if (r == 1) begin
                mtc0_write(ADDR_INDEX, rand_word());
                tlb_instr(1'b1, 1'b0, 1'b0);
                mfc0_read(ADDR_ENTRYHI);
                mfc0_read(ADDR_ENTRYLO0);
                mfc0_read(ADDR_ENTRYLO1);
            end else begin
                mtc0_write(ADDR_ENTRYHI, rand_hi());
                tlb_instr(1'b0, 1'b0, 1'b1);
                mfc0_read(ADDR_INDEX);
            end
        end
        report_test("tlb");

        start_test();
        repeat (TLBEXC_ROUNDS) begin
            issue_eret();
            raise_exc(EXC_TLBL, rand_pc(), rand_word(), 1'b0);
            mfc0_read(ADDR_ENTRYHI);
            mfc0_read(ADDR_BADVADDR);
            raise_exc(EXC_TLBS, rand_pc(), rand_word(), 1'b0);   // Nested
            mfc0_read(ADDR_ENTRYHI);
            mfc0_read(ADDR_BADVADDR);
        end
        report_test("tlb exception");

        violations = u_dut.u_exc_ctrl.u_props.violations;
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", tests_run,
                 check_count, err_count, violations);
        if (err_count == 0 && violations == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
src/cp0_pkg.sv
src/cp0_timer.sv
src/cp0_exc_ctrl.sv
src/cp0_tlb_regs.sv
src/tlb_array.sv
src/cp0_subsys.sv
tb/cp0_properties.sv
tb/tb_cp0_subsys.sv

//--- Bender.yml
package:
  name: cp0_subsys

sources:
  - src/cp0_pkg.sv
  - src/cp0_timer.sv
  - src/cp0_exc_ctrl.sv
  - src/cp0_tlb_regs.sv
  - src/tlb_array.sv
  - src/cp0_subsys.sv
  - target: simulation
    files:
      - tb/cp0_properties.sv
      - tb/tb_cp0_subsys.sv
